// File: hw/cache_pkg.sv
package cache_pkg;

  //////////////////////
  // bus widths
  //////////////////////
  localparam int ADDR_W = 16;           // byte address
  localparam int DATA_W = 16;           // one cpu word

  // block geometry
  localparam int WORDS_PER_BLOCK = 8;   // 16 bytes per block
  localparam int OFFSET_W        = 3;   // word select within the block

  //////////////////////
  // address fields
  //////////////////////
  localparam int OFFSET_LSB = 1;                      // bit 0 is the byte lane, ignored
  localparam int LINE_LSB   = OFFSET_LSB + OFFSET_W;  // line index starts at bit 4

  // backing store contents, word = byte address ^ pattern
  localparam logic [DATA_W-1:0] MEM_INIT_XOR = 16'h5a5a;

  // fill machine states
  typedef enum logic {
    FILL_IDLE,   // serving hits, passing writes through
    FILL_WAIT    // refilling a block from memory
  } fill_state_t;

endpackage

// File: hw/cache_ifs.sv
`timescale 1ns/1ps

// controller <-> main memory
interface mem_if import cache_pkg::*; ();
  logic              read_req;         // one word read per cycle while high
  logic              wrt_mem;          // write-through strobe
  logic [ADDR_W-1:0] memory_address;
  logic [DATA_W-1:0] memory_wdata;
  logic [DATA_W-1:0] memory_data;      // returned word
  logic              memory_data_vld;  // pulses MEM_LATENCY cycles after the read

  modport ctrl (
    output read_req, wrt_mem, memory_address, memory_wdata,
    input  memory_data, memory_data_vld
  );

  modport mem (
    input  read_req, wrt_mem, memory_address, memory_wdata,
    output memory_data, memory_data_vld
  );
endinterface

// controller -> tag and data arrays
interface array_if import cache_pkg::*; ();
  logic [ADDR_W-1:0] cache_addr;       // tag, line and offset for the write
  logic [DATA_W-1:0] array_wdata;
  logic              write_data_array; // one word into the data array
  logic              write_tag_array;  // tag + valid once the block is complete

  modport ctrl (output cache_addr, array_wdata, write_data_array, write_tag_array);

  modport array (input cache_addr, array_wdata, write_data_array, write_tag_array);
endinterface

// File: hw/cache_fill_ctrl.sv
`timescale 1ns/1ps

module cache_fill_ctrl import cache_pkg::*; #(
  parameter int MEM_LATENCY = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_rd,
  input  logic              cpu_wrt,
  input  logic [ADDR_W-1:0] cpu_addr,
  input  logic [DATA_W-1:0] cpu_wdata,
  input  logic              miss_detected,
  output logic              stall,
  mem_if.ctrl               mem,
  array_if.ctrl             arr
);

  // whole refill: 8 requests, then wait out the memory latency
  localparam int FILL_CYCLES = WORDS_PER_BLOCK + MEM_LATENCY;
  localparam int CNT_W       = $clog2(FILL_CYCLES);

  fill_state_t         state, nxt_state;
  logic [CNT_W-1:0]    cnt;        // request counter, only runs in FILL_WAIT
  logic [OFFSET_W-1:0] blck_off;   // where the next returning word lands
  logic                cpu_req;
  logic                filling;
  logic                reading;    // still issuing reads
  logic                done;       // final count of the fill

  assign cpu_req = cpu_rd | cpu_wrt;
  assign filling = (state == FILL_WAIT);
  assign reading = filling && (cnt < CNT_W'(WORDS_PER_BLOCK));
  assign done    = filling && (cnt == CNT_W'(FILL_CYCLES - 1));

  ////////////////////
  // counters
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (done) begin
      cnt <= '0;             // ready for the next miss
    end else if (filling) begin
      cnt <= cnt + 1'b1;
    end
  end

  // advances per returned word, reads may still be in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      blck_off <= '0;
    end else if (mem.memory_data_vld) begin
      blck_off <= blck_off + 1'b1;   // wraps to 0 after the 8th word
    end
  end

  ////////////////////
  // state machine
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= FILL_IDLE;
    end else begin
      state <= nxt_state;
    end
  end

  always_comb begin
    // defaults, idle pass-through addressing
    nxt_state            = state;
    stall                = 1'b0;
    mem.read_req         = 1'b0;
    mem.wrt_mem          = 1'b0;
    mem.memory_address   = cpu_addr;
    arr.cache_addr       = cpu_addr;
    arr.write_data_array = 1'b0;
    arr.write_tag_array  = 1'b0;
    case (state)
      FILL_IDLE: begin
        stall                = cpu_req & miss_detected;   // held until the block is in
        mem.wrt_mem          = cpu_wrt & ~miss_detected;  // write-through on a hit
        arr.write_data_array = cpu_wrt & ~miss_detected;  // same edge as memory
        if (cpu_req && miss_detected)
          nxt_state = FILL_WAIT;
      end
      FILL_WAIT: begin
        stall        = 1'b1;
        mem.read_req = reading;
        // miss block base plus request count
        mem.memory_address   = {cpu_addr[ADDR_W-1:LINE_LSB], cnt[OFFSET_W-1:0], 1'b0};
        arr.cache_addr       = {cpu_addr[ADDR_W-1:LINE_LSB], blck_off, 1'b0};
        arr.write_data_array = mem.memory_data_vld;
        arr.write_tag_array  = done;  // last word lands on this edge too
        if (done)
          nxt_state = FILL_IDLE;
      end
      default: nxt_state = FILL_IDLE;
    endcase
  end

  // write data only ever comes from the cpu
  assign mem.memory_wdata = cpu_wdata;
  assign arr.array_wdata  = filling ? mem.memory_data : cpu_wdata;  // fill vs write hit

endmodule

// File: hw/cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array import cache_pkg::*; #(
  parameter int NUM_LINES = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_rd,
  input  logic              cpu_wrt,
  input  logic [ADDR_W-1:0] cpu_addr,
  array_if.array            arr,
  output logic              miss_detected,
  output logic              hit
);

  localparam int LINE_W = $clog2(NUM_LINES);
  localparam int TAG_W  = ADDR_W - LINE_LSB - LINE_W;   // rest of the address

  logic [TAG_W-1:0]     tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid;
  logic [LINE_W-1:0]    rd_line, wr_line;
  logic [TAG_W-1:0]     rd_tag, wr_tag;
  logic                 tag_match;
  logic                 cpu_req;

  // lookup side from the cpu, update side from the fill controller
  assign rd_line = cpu_addr[LINE_LSB +: LINE_W];
  assign rd_tag  = cpu_addr[ADDR_W-1 -: TAG_W];
  assign wr_line = arr.cache_addr[LINE_LSB +: LINE_W];
  assign wr_tag  = arr.cache_addr[ADDR_W-1 -: TAG_W];

  always_ff @(posedge clk) begin
    if (rst)
      valid <= '0;                   // all lines empty
    else if (arr.write_tag_array)
      valid[wr_line] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (arr.write_tag_array)
      tags[wr_line] <= wr_tag;
  end

  assign cpu_req       = cpu_rd | cpu_wrt;
  assign tag_match     = valid[rd_line] && (tags[rd_line] == rd_tag);
  assign hit           = cpu_req & tag_match;
  assign miss_detected = cpu_req & ~tag_match;   // invalid line or other tag
endmodule

// File: hw/cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array import cache_pkg::*; #(
  parameter int NUM_LINES = 8
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] cpu_addr,
  array_if.array            arr,
  output logic [DATA_W-1:0] rdata
);

  localparam int LINE_W = $clog2(NUM_LINES);
  localparam int IDX_W  = LINE_W + OFFSET_W;   // {line, word offset}

  logic [DATA_W-1:0] words [NUM_LINES * WORDS_PER_BLOCK];
  logic [IDX_W-1:0]  rd_idx, wr_idx;

  ////////////////////
  // read port
  ////////////////////
  assign rd_idx = cpu_addr[OFFSET_LSB +: IDX_W];
  assign rdata  = words[rd_idx];   // combinational, no output reg

  ////////////////////
  // write port
  ////////////////////
  assign wr_idx = arr.cache_addr[OFFSET_LSB +: IDX_W];

  // fill words and write hits share this port
  always_ff @(posedge clk) begin
    if (arr.write_data_array)
      words[wr_idx] <= arr.array_wdata;
  end

endmodule

// File: hw/main_memory.sv
`timescale 1ns/1ps

module main_memory import cache_pkg::*; #(
  parameter int MEM_LATENCY = 4
) (
  input logic clk,
  input logic rst,
  mem_if.mem  mem
);

  localparam int WIDX_W = ADDR_W - OFFSET_LSB;   // word index bits
  localparam int DEPTH  = 1 << WIDX_W;           // 32K words

  logic [DATA_W-1:0]      words [DEPTH];
  logic [WIDX_W-1:0]      word_idx;
  logic [MEM_LATENCY-1:0] vld_pipe;                 // bit 0 is the newest request
  logic [DATA_W-1:0]      data_pipe [MEM_LATENCY];

  assign word_idx = mem.memory_address[ADDR_W-1:OFFSET_LSB];

  // preload, each word holds its own byte address xor'd with the pattern
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      words[i] = DATA_W'(i << OFFSET_LSB) ^ MEM_INIT_XOR;
    end
  end

  ////////////////////
  // read pipeline
  ////////////////////
  always_ff @(posedge clk) begin
    if (rst)
      vld_pipe <= '0;
    else
      vld_pipe <= (vld_pipe << 1) | MEM_LATENCY'(mem.read_req);
  end

  // payload follows the valid bits
  always_ff @(posedge clk) begin
    data_pipe[0] <= words[word_idx];
    for (int s = 1; s < MEM_LATENCY; s++) begin
      data_pipe[s] <= data_pipe[s-1];
    end
  end

  // oldest stage is the returning word
  assign mem.memory_data     = data_pipe[MEM_LATENCY-1];
  assign mem.memory_data_vld = vld_pipe[MEM_LATENCY-1];

  ////////////////////
  // write port
  ////////////////////
  always_ff @(posedge clk) begin
    if (mem.wrt_mem)
      words[word_idx] <= mem.memory_wdata;   // write-through from the cache
  end

endmodule

// File: hw/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
  parameter int NUM_LINES   = 8,
  parameter int MEM_LATENCY = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cpu_rd,
  input  logic              cpu_wrt,
  input  logic [ADDR_W-1:0] cpu_addr,
  input  logic [DATA_W-1:0] cpu_wdata,
  output logic [DATA_W-1:0] rdata,
  output logic              hit,
  output logic              stall
);

  mem_if   mem_bus ();   // controller <-> backing memory
  array_if arr_bus ();   // controller -> tag and data arrays

  logic miss_detected;   // tag array -> fill controller

  ////////////////////
  // control
  ////////////////////
  cache_fill_ctrl #(.MEM_LATENCY(MEM_LATENCY)) u_fill_ctrl (
    .clk, .rst, .cpu_rd, .cpu_wrt, .cpu_addr, .cpu_wdata,
    .miss_detected, .stall,
    .mem (mem_bus.ctrl),
    .arr (arr_bus.ctrl)
  );

  ////////////////////
  // storage
  ////////////////////
  cache_tag_array #(.NUM_LINES(NUM_LINES)) u_tag_array (
    .clk, .rst, .cpu_rd, .cpu_wrt, .cpu_addr,
    .arr (arr_bus.array),
    .miss_detected, .hit
  );

  cache_data_array #(.NUM_LINES(NUM_LINES)) u_data_array (
    .clk, .cpu_addr, .rdata,
    .arr (arr_bus.array)
  );

  main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_main_memory (
    .clk, .rst,
    .mem (mem_bus.mem)
  );

endmodule

// File: bench/cache_checker.sv
`timescale 1ns/1ps

module cache_checker #(
  parameter int NUM_LINES   = 8,
  parameter int MEM_LATENCY = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cpu_rd,
  input  logic        cpu_wrt,
  input  logic [15:0] cpu_addr,
  input  logic [15:0] cpu_wdata,
  input  logic [15:0] rdata,
  input  logic        hit,
  input  logic        stall,
  output int          err_count
);

  localparam int LINE_W     = $clog2(NUM_LINES);
  localparam int TAG_W      = 12 - LINE_W;           // bits above offset and line
  localparam int MISS_STALL = 1 + 8 + MEM_LATENCY;   // miss cycle + whole refill

  logic [15:0]          mem_model [32768];   // indexed by addr[15:1]
  logic [TAG_W-1:0]     tag_model [NUM_LINES];
  logic [NUM_LINES-1:0] vld_model;
  logic [LINE_W-1:0]    line;
  logic                 in_access = 1'b0;      // an access is being held
  logic                 exp_miss;
  int                   stall_cycles;
  int                   errs = 0;
  int                   accesses = 0;
  int                   test_errs0;
  int                   test_acc0;
  int                   tests_passed = 0;
  int                   tests_failed = 0;
  string                test_name = "none";

  assign err_count = errs;
  assign line      = cpu_addr[4 +: LINE_W];   // bits 3..1 pick the word

  task automatic mismatch(input string what, input logic [15:0] exp_v,
                          input logic [15:0] act_v);
    $display("Mismatch %s: %s at %h, expected %h actual %h",
             test_name, what, cpu_addr, exp_v, act_v);
    errs++;
  endtask

  // request high and stall low here, so the access retires on the next edge
  task automatic finish_access();
    logic [15:0] exp_stall;
    exp_stall = exp_miss ? 16'(MISS_STALL) : 16'd0;
    if (16'(stall_cycles) != exp_stall)
      mismatch("stall cycles", exp_stall, 16'(stall_cycles));
    if (!hit)
      mismatch("hit at completion", 16'd1, 16'd0);
    if (cpu_rd && rdata != mem_model[cpu_addr[15:1]])
      mismatch("rdata", mem_model[cpu_addr[15:1]], rdata);
    if (exp_miss) begin
      vld_model[line] = 1'b1;   // block now resident
      tag_model[line] = cpu_addr[15 -: TAG_W];
    end
    if (cpu_wrt)
      mem_model[cpu_addr[15:1]] = cpu_wdata;   // write-through
    accesses++;
    in_access = 1'b0;
  endtask

  ////////////////////
  // sampled mid-cycle, inputs and outputs settled
  ////////////////////
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32768; i++)
        mem_model[i] = 16'(i * 2) ^ 16'h5a5a;   // preload: byte address xor pattern
      vld_model = '0;
      in_access = 1'b0;
    end else if (cpu_rd || cpu_wrt) begin
      if (!in_access) begin
        in_access    = 1'b1;
        stall_cycles = 0;
        exp_miss     = !(vld_model[line] && tag_model[line] == cpu_addr[15 -: TAG_W]);
        if (hit == exp_miss)
          mismatch("hit on first cycle", {15'd0, !exp_miss}, {15'd0, hit});
      end
      if (stall)
        stall_cycles++;
      else
        finish_access();
    end else if (stall) begin
      $display("Error in %s: stall is high with no request pending", test_name);
      errs++;
    end
  end

  ////////////////////
  // per test bookkeeping
  ////////////////////
  task automatic begin_test(input string name);
    test_name  = name;
    test_errs0 = errs;
    test_acc0  = accesses;
  endtask

  task automatic end_test();
    if (errs == test_errs0) begin
      tests_passed++;
      $display("PASS %s (%0d accesses)", test_name, accesses - test_acc0);
    end else begin
      tests_failed++;
      $display("FAIL %s (%0d errors)", test_name, errs - test_errs0);
    end
  endtask

  task automatic report();
    $display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed, errs);
  endtask

endmodule

// File: bench/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

  localparam int NUM_LINES   = 8;
  localparam int MEM_LATENCY = 4;
  localparam int PERIOD      = 100;
  localparam int N_COLD      = 24;
  localparam int N_MIX       = 300;
  localparam int TOTAL_ACCESSES  = 1 + N_COLD + 9 + 5 + 9 + N_MIX;
  localparam int WATCHDOG_CYCLES = TOTAL_ACCESSES * (2 + 8 + MEM_LATENCY) + 100;

  logic        clk;
  logic        rst;
  logic        cpu_rd;
  logic        cpu_wrt;
  logic [15:0] cpu_addr;
  logic [15:0] cpu_wdata;
  logic [15:0] rdata;
  logic        hit;
  logic        stall;
  int          err_count;
  logic [31:0] seed;

  // port names match on both sides
  cache_top #(.NUM_LINES(NUM_LINES), .MEM_LATENCY(MEM_LATENCY)) dut (.*);
  cache_checker #(.NUM_LINES(NUM_LINES), .MEM_LATENCY(MEM_LATENCY)) chk (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;   // numerical recipes lcg
    return seed;
  endfunction

  // called 5 ns after an edge, returns 5 ns after the completing edge
  task automatic do_access(input logic wr, input logic [15:0] addr, input logic [15:0] wdata);
    cpu_rd    = !wr;
    cpu_wrt   = wr;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    @(negedge clk);
    while (stall)
      @(negedge clk);   // hold while the block fills
    @(posedge clk);
    #5;
    cpu_rd  = 1'b0;
    cpu_wrt = 1'b0;
  endtask

  //////////////////////
  // test sequences
  //////////////////////
  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    logic [15:0] a;
    seed      = 32'h0198a7a2;
    rst       = 1'b1;
    cpu_rd    = 1'b0;
    cpu_wrt   = 1'b0;
    cpu_addr  = 16'h0000;
    cpu_wdata = 16'h0000;
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;

    chk.begin_test("reset");
    @(posedge clk);   // one idle cycle, stall must stay low
    #5;
    r = next_rand();
    do_access(1'b0, {r[31:17], 1'b0}, 16'h0000);   // every line invalid, so a miss
    chk.end_test();

    chk.begin_test("cold reads");
    for (int n = 0; n < N_COLD; n++) begin
      r = next_rand();
      do_access(1'b0, 16'h0200 + {10'd0, r[28:24], 1'b0}, 16'h0000);   // 4 blocks
    end
    chk.end_test();

    chk.begin_test("block fill");
    do_access(1'b0, 16'h134a, 16'h0000);
    for (int i = 0; i < 8; i++)
      do_access(1'b0, 16'h1340 + 16'(2 * i), 16'h0000);
    chk.end_test();

    chk.begin_test("write hit");
    r = next_rand();
    a = 16'h2466;
    do_access(1'b0, a, 16'h0000);
    do_access(1'b1, a, r[31:16]);
    do_access(1'b0, a, 16'h0000);
    do_access(1'b0, a + 16'(NUM_LINES * 16), 16'h0000);   // same line, other tag
    do_access(1'b0, a, 16'h0000);                         // refetched from memory
    chk.end_test();

    chk.begin_test("write miss");
    r = next_rand();
    do_access(1'b1, 16'h3a84, r[31:16]);
    for (int i = 0; i < 8; i++)
      do_access(1'b0, 16'h3a80 + 16'(2 * i), 16'h0000);
    chk.end_test();

    chk.begin_test("random mix");
    for (int n = 0; n < N_MIX; n++) begin
      r  = next_rand();
      r2 = next_rand();
      a  = 16'h4000 | (r[31:16] & 16'(4 * NUM_LINES * 16 - 1) & 16'hfffe);   // 4 tags
      do_access(r2[29:28] == 2'b00, a, r2[31:16]);
    end
    chk.end_test();

    chk.report();
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // each access takes at most one miss plus a spare cycle
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: project.f
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/cache_fill_ctrl.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/main_memory.sv
hw/cache_top.sv
bench/cache_checker.sv
bench/cache_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then decide from the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -f project.f --top-module cache_tb -o cache_sim &&
./obj_dir/cache_sim > sim.log 2>&1 ||
echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
